/* fcpu_pkg.sv */
`default_nettype none

package fcpu_pkg;

   // Basic widths
   localparam int RSV_ID_W = 4;
   localparam int DATA_W = 32;
   localparam int ADDR_W = 10;
   localparam int IO_W = 8;
   localparam int INSTR_W = 4;

   // Issue queue sizing
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

   // Scratch RAM sizing, word index sits above the byte offset
   localparam int RAM_WORDS = 256;
   localparam int RAM_IDX_W = $clog2(RAM_WORDS);

   typedef logic [RSV_ID_W-1:0] rsv_id_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [IO_W-1:0] io_byte_t;
   typedef logic [INSTR_W-1:0] instr_t;
   typedef logic [RAM_IDX_W-1:0] ram_idx_t;
   typedef logic [QUEUE_PTR_W-1:0] qptr_t;
   typedef logic [QUEUE_PTR_W:0] qcount_t;

   localparam qcount_t QUEUE_FULL = qcount_t'(QUEUE_DEPTH);

   // Opcodes, anything else retires as a no-op
   localparam instr_t I_LOAD = 4'h1;
   localparam instr_t I_STORE = 4'h2;
   localparam instr_t I_OUTPUT = 4'h3;
   localparam instr_t I_INPUT = 4'h4;

   // One dispatched memory or I/O operation
   typedef struct packed {
      rsv_id_t rsv_id;
      instr_t  opcode;
      addr_t   address;
      word_t   data;
   } mem_req_t;

   // Common data bus broadcast
   typedef struct packed {
      rsv_id_t rsv_id;
      word_t   value;
   } cdb_t;

endpackage

`default_nettype wire

/* mem_issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_issue_queue (
   input  logic               clk,
   input  logic               nrst,
   input  fcpu_pkg::mem_req_t i_req,
   input  logic               i_req_valid,
   output logic               o_req_ready,
   output fcpu_pkg::mem_req_t o_head,
   output logic               o_head_valid,
   input  logic               i_head_ready
);

   fcpu_pkg::mem_req_t entries [fcpu_pkg::QUEUE_DEPTH];
   fcpu_pkg::qptr_t wr_ptr;
   fcpu_pkg::qptr_t rd_ptr;
   fcpu_pkg::qcount_t count;
   logic push;
   logic pop;

   assign o_req_ready = (count != fcpu_pkg::QUEUE_FULL);
   assign o_head_valid = (count != '0);
   assign o_head = entries[rd_ptr];

   assign push = i_req_valid && o_req_ready;
   assign pop = o_head_valid && i_head_ready;

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= i_req;
      end
   end

   // Pointers wrap naturally since depth is a power of two
   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + fcpu_pkg::qptr_t'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + fcpu_pkg::qptr_t'(1);
         end
         case ({push, pop})
            2'b10: begin
               count <= count + fcpu_pkg::qcount_t'(1);
            end
            2'b01: begin
               count <= count - fcpu_pkg::qcount_t'(1);
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

   // Occupancy stays within the buffer
   a_count_bound: assert property (
      @(posedge clk) disable iff (nrst)
      count <= fcpu_pkg::QUEUE_FULL
   ) else $error("issue queue count overflow");

endmodule

`default_nettype wire

/* memory_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_unit (
   input  logic               clk,
   input  logic               nrst,
   input  fcpu_pkg::mem_req_t i_req,
   input  logic               i_req_valid,
   output logic               o_req_ready,
   output fcpu_pkg::addr_t    o_aw_addr,
   output logic               o_aw_valid,
   input  logic               i_aw_ready,
   output fcpu_pkg::word_t    o_w_data,
   output logic               o_w_valid,
   input  logic               i_w_ready,
   input  logic               i_b_valid,
   output logic               o_b_ready,
   output fcpu_pkg::addr_t    o_ar_addr,
   output logic               o_ar_valid,
   input  logic               i_ar_ready,
   input  fcpu_pkg::word_t    i_r_data,
   input  logic               i_r_valid,
   output logic               o_r_ready,
   output fcpu_pkg::cdb_t     o_cdb,
   output logic               o_cdb_valid,
   input  logic               i_cdb_ready,
   output fcpu_pkg::io_byte_t o_io_out_data,
   output logic               o_io_out_valid,
   input  logic               i_io_out_ready,
   input  fcpu_pkg::io_byte_t i_io_in_data,
   input  logic               i_io_in_valid,
   output logic               o_io_in_ready
);

   typedef enum logic [2:0] {
      idle,
      wr_addr,
      wr_data,
      wr_resp,
      rd_addr,
      rd_data,
      io_out,
      io_in
   } state_t;

   state_t state;
   state_t state_n;
   fcpu_pkg::mem_req_t req_q;
   logic accept;

   assign o_req_ready = (state == idle);
   assign accept = i_req_valid && o_req_ready;

   // Latched operation drives the address, data and output ports
   assign o_aw_addr = req_q.address;
   assign o_ar_addr = req_q.address;
   assign o_w_data = req_q.data;
   assign o_io_out_data = req_q.data[fcpu_pkg::IO_W-1:0];

   assign o_aw_valid = (state == wr_addr);
   assign o_w_valid = (state == wr_data);
   assign o_b_ready = (state == wr_resp);
   assign o_ar_valid = (state == rd_addr);
   assign o_io_out_valid = (state == io_out);

   // Read data and input bytes pass straight to the CDB
   assign o_r_ready = (state == rd_data) && i_cdb_ready;
   assign o_io_in_ready = (state == io_in) && i_cdb_ready;

   always_comb begin
      o_cdb.rsv_id = req_q.rsv_id;
      o_cdb.value = i_r_data;
      o_cdb_valid = 1'b0;
      case (state)
         rd_data: begin
            o_cdb_valid = i_r_valid;
         end
         io_in: begin
            o_cdb.value = fcpu_pkg::word_t'(i_io_in_data);
            o_cdb_valid = i_io_in_valid;
         end
         default: begin
            o_cdb_valid = 1'b0;
         end
      endcase
   end

   always_comb begin
      state_n = state;
      case (state)
         idle: begin
            if (accept) begin
               case (i_req.opcode)
                  fcpu_pkg::I_LOAD: state_n = rd_addr;
                  fcpu_pkg::I_STORE: state_n = wr_addr;
                  fcpu_pkg::I_OUTPUT: state_n = io_out;
                  fcpu_pkg::I_INPUT: state_n = io_in;
                  // Unknown opcodes retire on acceptance
                  default: state_n = idle;
               endcase
            end
         end
         wr_addr: begin
            if (i_aw_ready) begin
               state_n = wr_data;
            end
         end
         wr_data: begin
            if (i_w_ready) begin
               state_n = wr_resp;
            end
         end
         wr_resp: begin
            if (i_b_valid) begin
               state_n = idle;
            end
         end
         rd_addr: begin
            if (i_ar_ready) begin
               state_n = rd_data;
            end
         end
         rd_data: begin
            if (i_r_valid && i_cdb_ready) begin
               state_n = idle;
            end
         end
         io_out: begin
            if (i_io_out_ready) begin
               state_n = idle;
            end
         end
         io_in: begin
            if (i_io_in_valid && i_cdb_ready) begin
               state_n = idle;
            end
         end
         default: begin
            state_n = idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= i_req;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= idle;
      end else begin
         state <= state_n;
      end
   end

   // Stalled broadcast keeps its payload
   a_cdb_hold: assert property (
      @(posedge clk) disable iff (nrst)
      o_cdb_valid && !i_cdb_ready |=> o_cdb_valid && $stable(o_cdb)
   ) else $error("CDB payload dropped or changed while stalled");

   a_axi_onehot: assert property (
      @(posedge clk) disable iff (nrst)
      $onehot0({o_aw_valid, o_w_valid, o_ar_valid})
   ) else $error("more than one AXI request channel active");

endmodule

`default_nettype wire

/* axi_scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_scratch_ram (
   input  logic            clk,
   input  logic            nrst,
   input  fcpu_pkg::addr_t i_aw_addr,
   input  logic            i_aw_valid,
   output logic            o_aw_ready,
   input  fcpu_pkg::word_t i_w_data,
   input  logic            i_w_valid,
   output logic            o_w_ready,
   output logic            o_b_valid,
   input  logic            i_b_ready,
   input  fcpu_pkg::addr_t i_ar_addr,
   input  logic            i_ar_valid,
   output logic            o_ar_ready,
   output fcpu_pkg::word_t o_r_data,
   output logic            o_r_valid,
   input  logic            i_r_ready
);

   typedef enum logic [1:0] {
      w_idle,
      w_data,
      w_resp
   } wr_state_t;

   typedef enum logic {
      r_idle,
      r_data
   } rd_state_t;

   fcpu_pkg::word_t mem [fcpu_pkg::RAM_WORDS];
   wr_state_t wr_state;
   rd_state_t rd_state;
   fcpu_pkg::ram_idx_t wr_idx;

   assign o_aw_ready = (wr_state == w_idle);
   assign o_w_ready = (wr_state == w_data);
   assign o_b_valid = (wr_state == w_resp);
   assign o_ar_ready = (rd_state == r_idle);
   assign o_r_valid = (rd_state == r_data);

   // Words read as zero until written
   always_ff @(posedge clk) begin
      if (nrst) begin
         for (int i = 0; i < fcpu_pkg::RAM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         // Byte offset bits are dropped
         if (i_aw_valid && o_aw_ready) begin
            wr_idx <= i_aw_addr[fcpu_pkg::RAM_IDX_W+1:2];
         end
         if (i_w_valid && o_w_ready) begin
            mem[wr_idx] <= i_w_data;
         end
         if (i_ar_valid && o_ar_ready) begin
            o_r_data <= mem[i_ar_addr[fcpu_pkg::RAM_IDX_W+1:2]];
         end
      end
   end

   // Write side
   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_state <= w_idle;
      end else begin
         case (wr_state)
            w_idle: begin
               if (i_aw_valid) begin
                  wr_state <= w_data;
               end
            end
            w_data: begin
               if (i_w_valid) begin
                  wr_state <= w_resp;
               end
            end
            w_resp: begin
               if (i_b_ready) begin
                  wr_state <= w_idle;
               end
            end
            default: begin
               wr_state <= w_idle;
            end
         endcase
      end
   end

   // Read side
   always_ff @(posedge clk) begin
      if (nrst) begin
         rd_state <= r_idle;
      end else begin
         case (rd_state)
            r_idle: begin
               if (i_ar_valid) begin
                  rd_state <= r_data;
               end
            end
            r_data: begin
               if (i_r_ready) begin
                  rd_state <= r_idle;
               end
            end
            default: begin
               rd_state <= r_idle;
            end
         endcase
      end
   end

   a_r_hold: assert property (
      @(posedge clk) disable iff (nrst)
      o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r_data)
   ) else $error("read data withdrawn before r ready");

endmodule

`default_nettype wire

/* mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
   input  logic               clk,
   input  logic               nrst,
   input  fcpu_pkg::mem_req_t i_req,
   input  logic               i_req_valid,
   output logic               o_req_ready,
   output fcpu_pkg::cdb_t     o_cdb,
   output logic               o_cdb_valid,
   input  logic               i_cdb_ready,
   output fcpu_pkg::io_byte_t o_io_out_data,
   output logic               o_io_out_valid,
   input  logic               i_io_out_ready,
   input  fcpu_pkg::io_byte_t i_io_in_data,
   input  logic               i_io_in_valid,
   output logic               o_io_in_ready
);

   fcpu_pkg::mem_req_t head;
   logic head_valid;
   logic head_ready;

   // AXI between memory unit and scratch RAM
   fcpu_pkg::addr_t aw_addr;
   logic aw_valid;
   logic aw_ready;
   fcpu_pkg::word_t w_data;
   logic w_valid;
   logic w_ready;
   logic b_valid;
   logic b_ready;
   fcpu_pkg::addr_t ar_addr;
   logic ar_valid;
   logic ar_ready;
   fcpu_pkg::word_t r_data;
   logic r_valid;
   logic r_ready;

   mem_issue_queue queue_i (
      .clk          (clk),
      .nrst         (nrst),
      .i_req        (i_req),
      .i_req_valid  (i_req_valid),
      .o_req_ready  (o_req_ready),
      .o_head       (head),
      .o_head_valid (head_valid),
      .i_head_ready (head_ready)
   );

   memory_unit mem_unit_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_req          (head),
      .i_req_valid    (head_valid),
      .o_req_ready    (head_ready),
      .o_aw_addr      (aw_addr),
      .o_aw_valid     (aw_valid),
      .i_aw_ready     (aw_ready),
      .o_w_data       (w_data),
      .o_w_valid      (w_valid),
      .i_w_ready      (w_ready),
      .i_b_valid      (b_valid),
      .o_b_ready      (b_ready),
      .o_ar_addr      (ar_addr),
      .o_ar_valid     (ar_valid),
      .i_ar_ready     (ar_ready),
      .i_r_data       (r_data),
      .i_r_valid      (r_valid),
      .o_r_ready      (r_ready),
      .o_cdb          (o_cdb),
      .o_cdb_valid    (o_cdb_valid),
      .i_cdb_ready    (i_cdb_ready),
      .o_io_out_data  (o_io_out_data),
      .o_io_out_valid (o_io_out_valid),
      .i_io_out_ready (i_io_out_ready),
      .i_io_in_data   (i_io_in_data),
      .i_io_in_valid  (i_io_in_valid),
      .o_io_in_ready  (o_io_in_ready)
   );

   axi_scratch_ram ram_i (
      .clk        (clk),
      .nrst       (nrst),
      .i_aw_addr  (aw_addr),
      .i_aw_valid (aw_valid),
      .o_aw_ready (aw_ready),
      .i_w_data   (w_data),
      .i_w_valid  (w_valid),
      .o_w_ready  (w_ready),
      .o_b_valid  (b_valid),
      .i_b_ready  (b_ready),
      .i_ar_addr  (ar_addr),
      .i_ar_valid (ar_valid),
      .o_ar_ready (ar_ready),
      .o_r_data   (r_data),
      .o_r_valid  (r_valid),
      .i_r_ready  (r_ready)
   );

endmodule

`default_nettype wire

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

   localparam int NUM_OPS = 300;
   localparam int STREAM_LEN = 512;

   logic clk;
   logic nrst;
   fcpu_pkg::mem_req_t req;
   logic req_valid;
   logic req_ready;
   fcpu_pkg::cdb_t cdb;
   logic cdb_valid;
   logic cdb_ready;
   fcpu_pkg::io_byte_t out_data;
   logic out_valid;
   logic out_ready;
   fcpu_pkg::io_byte_t in_data;
   logic in_valid;
   logic in_ready;

   integer seed;
   fcpu_pkg::word_t model_mem [fcpu_pkg::RAM_WORDS];
   fcpu_pkg::io_byte_t in_stream [STREAM_LEN];
   fcpu_pkg::mem_req_t ops [$];
   fcpu_pkg::cdb_t exp_cdb [$];
   fcpu_pkg::io_byte_t exp_out [$];
   int model_in_pos;
   int in_pos;
   int dispatched;
   logic req_taken;
   logic in_taken;
   logic stall_cdb;
   logic cdb_stalled;
   fcpu_pkg::cdb_t stalled_cdb;

   mem_subsystem_top dut_i (
      .clk            (clk),
      .nrst           (nrst),
      .i_req          (req),
      .i_req_valid    (req_valid),
      .o_req_ready    (req_ready),
      .o_cdb          (cdb),
      .o_cdb_valid    (cdb_valid),
      .i_cdb_ready    (cdb_ready),
      .o_io_out_data  (out_data),
      .o_io_out_valid (out_valid),
      .i_io_out_ready (out_ready),
      .i_io_in_data   (in_data),
      .i_io_in_valid  (in_valid),
      .o_io_in_ready  (in_ready)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
         $display("Something failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic gen_op(output fcpu_pkg::mem_req_t op);
      logic [31:0] r;
      r = next_rand();
      op.rsv_id = r[3:0];
      // Small word range with a random byte offset that the RAM ignores
      op.address = fcpu_pkg::addr_t'({r[7:4], r[9:8]});
      op.data = next_rand();
      case (r[12:10])
         3'd0, 3'd1, 3'd2: op.opcode = fcpu_pkg::I_LOAD;
         3'd3, 3'd4: op.opcode = fcpu_pkg::I_STORE;
         3'd5: op.opcode = fcpu_pkg::I_OUTPUT;
         3'd6: op.opcode = fcpu_pkg::I_INPUT;
         default: op.opcode = 4'h5 + {1'b0, r[15:13]};
      endcase
   endtask

   // Reference model applied in dispatch order
   task automatic model_accept(input fcpu_pkg::mem_req_t op);
      fcpu_pkg::cdb_t e;
      e.rsv_id = op.rsv_id;
      case (op.opcode)
         fcpu_pkg::I_LOAD: begin
            e.value = model_mem[op.address[fcpu_pkg::ADDR_W-1:2]];
            exp_cdb.push_back(e);
         end
         fcpu_pkg::I_STORE: begin
            model_mem[op.address[fcpu_pkg::ADDR_W-1:2]] = op.data;
         end
         fcpu_pkg::I_OUTPUT: begin
            exp_out.push_back(op.data[fcpu_pkg::IO_W-1:0]);
         end
         fcpu_pkg::I_INPUT: begin
            e.value = {24'h000000, in_stream[model_in_pos]};
            model_in_pos++;
            exp_cdb.push_back(e);
         end
         default: begin
         end
      endcase
   endtask

   // Transfers that will happen on the coming rising edge
   task automatic observe_outputs();
      fcpu_pkg::cdb_t e;
      fcpu_pkg::io_byte_t b;
      if (cdb_stalled) begin
         check_value(64'(cdb_valid), 64'(1), "CDB valid dropped while stalled");
         check_value(64'(cdb), 64'(stalled_cdb), "CDB payload changed while stalled");
      end
      if (cdb_valid && cdb_ready) begin
         if (exp_cdb.size() == 0) begin
            report_failure("A CDB broadcast appeared with no load or input pending");
         end else begin
            e = exp_cdb.pop_front();
            check_value(64'(cdb), 64'(e), "CDB broadcast");
         end
      end
      cdb_stalled = cdb_valid && !cdb_ready;
      stalled_cdb = cdb;
      if (out_valid && out_ready) begin
         if (exp_out.size() == 0) begin
            report_failure("A serial output byte appeared with no output operation pending");
         end else begin
            b = exp_out.pop_front();
            check_value(64'(out_data), 64'(b), "serial output byte");
         end
      end
      if (req_valid && req_ready) begin
         model_accept(req);
         req_taken = 1'b1;
         dispatched++;
      end
      if (in_valid && in_ready) begin
         in_taken = 1'b1;
      end
   endtask

   task automatic step_cycle();
      logic [31:0] r;
      @(negedge clk);
      if (req_taken) begin
         req_valid = 1'b0;
      end
      if (in_taken) begin
         in_valid = 1'b0;
         in_pos++;
      end
      req_taken = 1'b0;
      in_taken = 1'b0;
      r = next_rand();
      if (!req_valid && ops.size() > 0 && r[1:0] != 2'b00) begin
         req = ops.pop_front();
         req_valid = 1'b1;
      end
      cdb_ready = stall_cdb ? 1'b0 : r[2];
      out_ready = r[3];
      if (!in_valid) begin
         in_valid = r[4];
      end
      in_data = in_stream[in_pos];
      #1;
      observe_outputs();
   endtask

   function automatic logic all_drained();
      all_drained = (ops.size() == 0) && !req_valid && (exp_cdb.size() == 0) &&
                    (exp_out.size() == 0);
   endfunction

   task automatic wait_drained(input int limit, input string what);
      int n;
      n = 0;
      while (!all_drained() && n < limit) begin
         step_cycle();
         n++;
      end
      if (!all_drained()) begin
         report_failure({"Timeout while waiting for ", what, " to complete"});
      end
   endtask

   initial begin
      fcpu_pkg::mem_req_t op;
      int n;
      int start_count;
      clk = 1'b0;
      nrst = 1'b1;
      req = '0;
      req_valid = 1'b0;
      cdb_ready = 1'b0;
      out_ready = 1'b0;
      in_data = '0;
      in_valid = 1'b0;
      seed = 32'h271a;
      model_in_pos = 0;
      in_pos = 0;
      dispatched = 0;
      req_taken = 1'b0;
      in_taken = 1'b0;
      stall_cdb = 1'b0;
      cdb_stalled = 1'b0;
      stalled_cdb = '0;
      for (int i = 0; i < fcpu_pkg::RAM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < STREAM_LEN; i++) begin
         in_stream[i] = fcpu_pkg::io_byte_t'(next_rand());
      end

      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value(64'(cdb_valid), 64'(0), "CDB valid after reset");
      check_value(64'(out_valid), 64'(0), "serial output valid after reset");
      check_value(64'(req_ready), 64'(1), "queue ready after reset");
      nrst = 1'b0;

      for (int i = 0; i < NUM_OPS; i++) begin
         gen_op(op);
         ops.push_back(op);
      end
      wait_drained(20000, "the random operations");
      repeat (20) step_cycle();

      // Loads with the CDB held off fill the unit and the queue
      stall_cdb = 1'b1;
      start_count = dispatched;
      for (int i = 0; i < 8; i++) begin
         gen_op(op);
         op.opcode = fcpu_pkg::I_LOAD;
         ops.push_back(op);
      end
      n = 0;
      while (req_ready && n < 200) begin
         step_cycle();
         n++;
      end
      if (req_ready) begin
         report_failure("Timeout: the issue queue never filled while the CDB was stalled");
      end
      check_value(64'(dispatched - start_count), 64'(fcpu_pkg::QUEUE_DEPTH + 1),
                  "operations accepted before the queue filled");
      for (int i = 0; i < 10; i++) begin
         step_cycle();
         check_value(64'(req_ready), 64'(0), "queue ready while full");
      end
      stall_cdb = 1'b0;
      wait_drained(2000, "the stalled loads");

      // Quiet period catches late or extra broadcasts
      repeat (20) step_cycle();
      check_value(64'(in_pos), 64'(model_in_pos), "input bytes consumed");
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* fcpu_mem.f */
fcpu_pkg.sv
mem_issue_queue.sv
memory_unit.sv
axi_scratch_ram.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* Makefile */
# Verilator flow for the fcpu_mem memory subsystem

VERILATOR ?= verilator
FILELIST  ?= fcpu_mem.f
TB_TOP    ?= tb_mem_subsystem
RTL_TOP   ?= mem_subsystem_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --assert
LINTFLAGS ?= -Wall
PASS_MSG  ?= Everything OK

RTL_SRCS ?= fcpu_pkg.sv mem_issue_queue.sv memory_unit.sv axi_scratch_ram.sv \
            mem_subsystem_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
